//--- hdl/mbus_rx_pkg.sv
`default_nettype none

package mbus_rx_pkg;

    // host frame byte and mbus word widths
    localparam int byte_width = 8;
    localparam int mbus_word_width = 32;

    // first byte of every host frame
    localparam logic [byte_width-1:0] frame_flag_byte = 8'h62;

    // short address, all ones means unassigned or no override
    localparam int short_addr_width = 4;
    localparam logic [short_addr_width-1:0] short_addr_none = '1;

    // rx_ack length after a failed reception
    localparam int fail_ack_cycles = 3;

    // receive sequencing states
    typedef enum logic [2:0] {
        st_idle,
        st_flag,
        st_time_tag,
        st_capture,
        st_shift,
        st_check,
        st_status,
        st_fail_ack
    } rx_state_t;

endpackage

`default_nettype wire

//--- hdl/mbus_clock_divider.sv
`timescale 1ns/100ps
`default_nettype none

module mbus_clock_divider #(
    parameter int clk_div_width = 22
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic [clk_div_width-1:0] clk_div,
    output logic                     mbus_clk,
    output logic                     mbus_clk_rise
);

    logic [clk_div_width-1:0] div_count;
    logic                     div_wrap;

    // half period ends when the count reaches clk_div
    assign div_wrap = (div_count == clk_div);

    always_ff @(posedge clk) begin
        if (reset) begin
            div_count     <= '0;
            mbus_clk      <= 1'b0;
            mbus_clk_rise <= 1'b0;
        end else begin
            div_count     <= div_wrap ? '0 : div_count + 1'b1;
            // flip mbus_clk once per half period
            if (div_wrap) begin
                mbus_clk <= ~mbus_clk;
            end
            // rising edge enable, lines up with mbus_clk going high
            mbus_clk_rise <= div_wrap & ~mbus_clk;
        end
    end

    // enable marks only a low to high transition of mbus_clk
    rise_only_on_edge: assert property (
        @(posedge clk) disable iff (reset)
        mbus_clk_rise |-> (mbus_clk && !$past(mbus_clk))
    );

endmodule

`default_nettype wire

//--- hdl/short_addr_register.sv
`timescale 1ns/100ps
`default_nettype none

module short_addr_register
    import mbus_rx_pkg::*;
(
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        mbus_clk_rise,
    input  logic                        assigned_addr_write,
    input  logic                        assigned_addr_invalid_n,
    input  logic [short_addr_width-1:0] assigned_addr_out,
    input  logic [short_addr_width-1:0] short_addr_override,
    output logic [short_addr_width-1:0] assigned_addr,
    output logic                        assigned_addr_valid
);

    // address as set by the mbus controller
    logic [short_addr_width-1:0] reg_addr;
    logic                        reg_valid;

    // controller levels only looked at on divided clock rising edges
    always_ff @(posedge clk) begin
        if (reset) begin
            reg_addr  <= short_addr_none;
            reg_valid <= 1'b0;
        end else if (mbus_clk_rise) begin
            // write wins over invalidate
            if (assigned_addr_write) begin
                reg_addr  <= assigned_addr_out;
                reg_valid <= 1'b1;
            end else if (!assigned_addr_invalid_n) begin
                reg_addr  <= short_addr_none;
                reg_valid <= 1'b0;
            end
        end
    end

    // host override replaces the register contents
    always_comb begin
        if (short_addr_override != short_addr_none) begin
            assigned_addr       = short_addr_override;
            assigned_addr_valid = 1'b1;
        end else begin
            assigned_addr       = reg_addr;
            assigned_addr_valid = reg_valid;
        end
    end

endmodule

`default_nettype wire

//--- hdl/rx_word_shifter.sv
`timescale 1ns/100ps
`default_nettype none

module rx_word_shifter
    import mbus_rx_pkg::*;
(
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       load_first,
    input  logic                       load_next,
    input  logic                       shift,
    input  logic [mbus_word_width-1:0] rx_addr,
    input  logic [mbus_word_width-1:0] rx_data,
    output logic [byte_width-1:0]      out_byte,
    output logic [3:0]                 bytes_left
);

    // bytes in an address plus data word pair, and in a data word alone
    localparam int pair_bytes = 2 * mbus_word_width / byte_width;
    localparam int word_bytes = mbus_word_width / byte_width;
    localparam int sr_width = 2 * mbus_word_width;

    logic [sr_width-1:0] data_sr;

    // payload register
    always_ff @(posedge clk) begin
        if (load_first) begin
            // address goes out first
            data_sr <= {rx_addr, rx_data};
        end else if (load_next) begin
            // later words carry data only, top half
            data_sr <= {rx_data, {mbus_word_width{1'b0}}};
        end else if (shift) begin
            data_sr <= {data_sr[sr_width-byte_width-1:0], {byte_width{1'b0}}};
        end
    end

    // byte count
    always_ff @(posedge clk) begin
        if (reset) begin
            bytes_left <= '0;
        end else if (load_first) begin
            bytes_left <= 4'(pair_bytes);
        end else if (load_next) begin
            bytes_left <= 4'(word_bytes);
        end else if (shift) begin
            bytes_left <= bytes_left - 1'b1;
        end
    end

    // most significant byte first
    assign out_byte = data_sr[sr_width-1 -: byte_width];

    // controller must stop shifting once the word is drained
    no_shift_when_empty: assert property (
        @(posedge clk) disable iff (reset)
        shift |-> (bytes_left != '0)
    );

endmodule

`default_nettype wire

//--- hdl/rx_frame_controller.sv
`timescale 1ns/100ps
`default_nettype none

module rx_frame_controller
    import mbus_rx_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  rx_req,
    input  logic                  rx_pend,
    input  logic                  rx_fail,
    input  logic                  rx_broadcast,
    input  logic [1:0]            rx_control_bits,
    input  logic [byte_width-1:0] global_counter,
    input  logic [byte_width-1:0] shifter_byte,
    input  logic [3:0]            bytes_left,
    output logic                  load_first,
    output logic                  load_next,
    output logic                  shift,
    output logic                  rx_ack,
    output logic                  global_counter_inc,
    output logic                  frame_valid,
    output logic                  frame_data_valid,
    output logic [byte_width-1:0] frame_data
);

    localparam int fail_cnt_width = $clog2(fail_ack_cycles);

    rx_state_t state;
    rx_state_t next_state;

    // two flop synchronizers for the request and failure levels
    logic [1:0] req_sync;
    logic [1:0] fail_sync;
    logic       req_s;
    logic       fail_s;

    // per message bookkeeping
    logic                      first_word;
    logic                      pend_q;
    logic [3:0]                status_bits;
    logic [fail_cnt_width-1:0] fail_cnt;

    assign req_s  = req_sync[1];
    assign fail_s = fail_sync[1];

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= st_idle;
            req_sync    <= '0;
            fail_sync   <= '0;
            first_word  <= 1'b1;
            pend_q      <= 1'b0;
            status_bits <= '0;
            fail_cnt    <= '0;
        end else begin
            state     <= next_state;
            req_sync  <= {req_sync[0], rx_req};
            fail_sync <= {fail_sync[0], rx_fail};
            case (state)
                st_idle: begin
                    // fresh message
                    first_word  <= 1'b1;
                    status_bits <= '0;
                    fail_cnt    <= '0;
                end
                st_capture: begin
                    // pend and status sampled while rx_req still held
                    first_word  <= 1'b0;
                    pend_q      <= rx_pend;
                    status_bits <= status_bits | {rx_fail, rx_broadcast, rx_control_bits};
                end
                st_fail_ack: begin
                    fail_cnt <= fail_cnt + 1'b1;
                end
                default: begin
                end
            endcase
        end
    end

    always_comb begin
        next_state         = state;
        load_first         = 1'b0;
        load_next          = 1'b0;
        shift              = 1'b0;
        rx_ack             = 1'b0;
        global_counter_inc = 1'b0;
        frame_valid        = 1'b0;
        frame_data_valid   = 1'b0;
        frame_data         = shifter_byte;
        case (state)
            st_idle: begin
                // request beats failure
                if (req_s) begin
                    next_state = st_flag;
                end else if (fail_s) begin
                    next_state = st_fail_ack;
                end
            end
            st_flag: begin
                frame_valid      = 1'b1;
                frame_data_valid = 1'b1;
                frame_data       = frame_flag_byte;
                next_state       = st_time_tag;
            end
            st_time_tag: begin
                // time tag sent once, counter told to advance
                frame_valid        = 1'b1;
                frame_data_valid   = 1'b1;
                frame_data         = global_counter;
                global_counter_inc = 1'b1;
                next_state         = st_capture;
            end
            st_capture: begin
                // no byte this cycle
                frame_valid = 1'b1;
                rx_ack      = 1'b1;
                load_first  = first_word;
                load_next   = ~first_word;
                next_state  = st_shift;
            end
            st_shift: begin
                frame_valid = 1'b1;
                if (bytes_left != '0) begin
                    shift            = 1'b1;
                    frame_data_valid = 1'b1;
                end
                // last byte goes out this cycle
                if (bytes_left <= 4'd1) begin
                    next_state = st_check;
                end
            end
            st_check: begin
                frame_valid = 1'b1;
                // more words pending, wait for the next request
                if (pend_q) begin
                    if (req_s) begin
                        next_state = st_capture;
                    end
                end else begin
                    next_state = st_status;
                end
            end
            st_status: begin
                frame_valid      = 1'b1;
                frame_data_valid = 1'b1;
                frame_data       = {{(byte_width - 4){1'b0}}, status_bits};
                next_state       = st_idle;
            end
            st_fail_ack: begin
                // ack held for fail_ack_cycles
                rx_ack = 1'b1;
                if (fail_cnt == fail_cnt_width'(fail_ack_cycles - 1)) begin
                    next_state = st_idle;
                end
            end
            default: begin
                next_state = st_idle;
            end
        endcase
    end

    // word ack never overlaps the byte stream
    no_ack_while_shifting: assert property (
        @(posedge clk) disable iff (reset)
        (state == st_shift) |-> !rx_ack
    );

endmodule

`default_nettype wire

//--- hdl/mbus_rx_bridge.sv
`timescale 1ns/100ps
`default_nettype none

module mbus_rx_bridge
    import mbus_rx_pkg::*;
#(
    parameter int clk_div_width = 22
) (
    input  logic                        clk,
    input  logic                        reset,
    input  logic [clk_div_width-1:0]    clk_div,
    output logic                        mbus_clk,
    input  logic [short_addr_width-1:0] short_addr_override,
    input  logic [short_addr_width-1:0] assigned_addr_out,
    input  logic                        assigned_addr_write,
    input  logic                        assigned_addr_invalid_n,
    output logic [short_addr_width-1:0] assigned_addr,
    output logic                        assigned_addr_valid,
    input  logic [mbus_word_width-1:0]  rx_addr,
    input  logic [mbus_word_width-1:0]  rx_data,
    input  logic                        rx_req,
    input  logic                        rx_pend,
    input  logic                        rx_fail,
    input  logic                        rx_broadcast,
    input  logic [1:0]                  rx_control_bits,
    output logic                        rx_ack,
    input  logic [byte_width-1:0]       global_counter,
    output logic                        global_counter_inc,
    output logic                        frame_valid,
    output logic                        frame_data_valid,
    output logic [byte_width-1:0]       frame_data
);

    // divider to address register
    logic mbus_clk_rise;

    // controller and shifter handshake
    logic                  load_first;
    logic                  load_next;
    logic                  shift;
    logic [3:0]            bytes_left;
    logic [byte_width-1:0] shifter_byte;

    mbus_clock_divider #(
        .clk_div_width(clk_div_width)
    ) u_clock_divider (
        .clk          (clk),
        .reset        (reset),
        .clk_div      (clk_div),
        .mbus_clk     (mbus_clk),
        .mbus_clk_rise(mbus_clk_rise)
    );

    short_addr_register u_short_addr (
        .clk                    (clk),
        .reset                  (reset),
        .mbus_clk_rise          (mbus_clk_rise),
        .assigned_addr_write    (assigned_addr_write),
        .assigned_addr_invalid_n(assigned_addr_invalid_n),
        .assigned_addr_out      (assigned_addr_out),
        .short_addr_override    (short_addr_override),
        .assigned_addr          (assigned_addr),
        .assigned_addr_valid    (assigned_addr_valid)
    );

    rx_word_shifter u_word_shifter (
        .clk       (clk),
        .reset     (reset),
        .load_first(load_first),
        .load_next (load_next),
        .shift     (shift),
        .rx_addr   (rx_addr),
        .rx_data   (rx_data),
        .out_byte  (shifter_byte),
        .bytes_left(bytes_left)
    );

    rx_frame_controller u_frame_ctrl (
        .clk               (clk),
        .reset             (reset),
        .rx_req            (rx_req),
        .rx_pend           (rx_pend),
        .rx_fail           (rx_fail),
        .rx_broadcast      (rx_broadcast),
        .rx_control_bits   (rx_control_bits),
        .global_counter    (global_counter),
        .shifter_byte      (shifter_byte),
        .bytes_left        (bytes_left),
        .load_first        (load_first),
        .load_next         (load_next),
        .shift             (shift),
        .rx_ack            (rx_ack),
        .global_counter_inc(global_counter_inc),
        .frame_valid       (frame_valid),
        .frame_data_valid  (frame_data_valid),
        .frame_data        (frame_data)
    );

endmodule

`default_nettype wire

//--- verification/rx_bridge_checker.sv
`timescale 1ns/100ps
`default_nettype none

module rx_bridge_checker
    import mbus_rx_pkg::*;
#(
    parameter int clk_div_width = 22
) (
    input wire logic                        clk,
    input wire logic                        reset,
    input wire logic                        frame_valid,
    input wire logic                        frame_data_valid,
    input wire logic [byte_width-1:0]       frame_data,
    input wire logic                        global_counter_inc,
    input wire logic [byte_width-1:0]       global_counter,
    input wire logic                        rx_ack,
    input wire logic                        mbus_clk,
    input wire logic [clk_div_width-1:0]    clk_div,
    input wire logic [short_addr_width-1:0] assigned_addr,
    input wire logic                        assigned_addr_valid
);

    // expected frame bytes without the time tag
    logic [byte_width-1:0] exp_bytes[$];
    // expected rx_ack high lengths for each word or failure
    int exp_acks[$];

    int check_count = 0;
    int error_count = 0;
    int frames_seen = 0;
    int period_checks = 0;

    int byte_idx;
    int ack_run;
    int half_cnt;
    bit half_clean;
    bit seen_toggle;
    logic last_mbus_clk;
    logic last_frame_valid;
    logic [clk_div_width-1:0] last_clk_div;

    function automatic void compare_value(input string name, input logic [31:0] expected,
                                          input logic [31:0] actual);
        check_count++;
        if (expected !== actual) begin
            error_count++;
            $display("Error at %0t: %s expected %0h got %0h", $time, name, expected, actual);
        end
    endfunction

    function automatic void report_failure(input string what);
        error_count++;
        $display("failure at %0t: %s", $time, what);
    endfunction

    task automatic expect_byte(input logic [byte_width-1:0] value);
        exp_bytes.push_back(value);
    endtask

    task automatic expect_ack(input int cycles);
        exp_acks.push_back(cycles);
    endtask

    // called by the testbench on a falling edge
    task automatic check_addr(input logic [short_addr_width-1:0] addr, input logic valid);
        compare_value("assigned_addr", addr, assigned_addr);
        compare_value("assigned_addr_valid", valid, assigned_addr_valid);
    endtask

    task automatic finish_checks(input int frames_expected);
        compare_value("frame count", frames_expected, frames_seen);
        if (exp_bytes.size() != 0) begin
            report_failure("expected frame bytes never arrived");
        end
        if (exp_acks.size() != 0) begin
            report_failure("expected rx_ack pulses never arrived");
        end
        if (period_checks == 0) begin
            report_failure("no mbus_clk half period was measured");
        end
    endtask

    // everything sampled mid cycle away from the driving edge
    always @(negedge clk) begin
        if (reset) begin
            byte_idx = 0;
            ack_run = 0;
            half_cnt = 0;
            half_clean = 1'b0;
            seen_toggle = 1'b0;
            last_mbus_clk = mbus_clk;
            last_frame_valid = 1'b0;
            last_clk_div = clk_div;
        end else begin
            if (frame_data_valid && !frame_valid) begin
                report_failure("frame_data_valid strobed outside frame_valid");
            end
            if (frame_data_valid && frame_valid) begin
                // second byte of a frame is the time tag
                compare_value("global_counter_inc", byte_idx == 1, global_counter_inc);
                if (byte_idx == 1) begin
                    compare_value("frame_data", global_counter, frame_data);
                end else if (exp_bytes.size() == 0) begin
                    report_failure("frame byte arrived with none expected");
                end else begin
                    compare_value("frame_data", exp_bytes.pop_front(), frame_data);
                end
                byte_idx++;
            end else if (global_counter_inc) begin
                report_failure("global_counter_inc pulsed without a byte strobe");
            end
            // all bytes must be out by the end of the frame
            if (last_frame_valid && !frame_valid) begin
                frames_seen++;
                if (exp_bytes.size() != 0) begin
                    report_failure("frame ended before all expected bytes arrived");
                end
                byte_idx = 0;
            end
            last_frame_valid = frame_valid;

            // length of each rx_ack high run
            if (rx_ack) begin
                ack_run++;
            end else if (ack_run != 0) begin
                if (exp_acks.size() == 0) begin
                    report_failure("rx_ack pulsed with no word or failure outstanding");
                end else begin
                    compare_value("rx_ack high cycles", exp_acks.pop_front(), ack_run);
                end
                ack_run = 0;
            end

            // half period in clk cycles skipped if clk_div moved during it
            half_cnt++;
            if (mbus_clk != last_mbus_clk) begin
                if (seen_toggle && half_clean) begin
                    compare_value("mbus_clk half period", clk_div + 1, half_cnt);
                    period_checks++;
                end
                seen_toggle = 1'b1;
                half_clean = 1'b1;
                half_cnt = 0;
            end
            if (clk_div != last_clk_div) begin
                half_clean = 1'b0;
            end
            last_clk_div = clk_div;
            last_mbus_clk = mbus_clk;
        end
    end

endmodule

`default_nettype wire

//--- verification/tb_mbus_rx_bridge.sv
`timescale 1ns/100ps
`default_nettype none

module tb_mbus_rx_bridge
    import mbus_rx_pkg::*;
();

    localparam int clk_div_width = 22;
    // cycle limit of every wait loop
    localparam int wait_limit = 500;

    logic                        clk;
    logic                        reset;
    logic [clk_div_width-1:0]    clk_div;
    logic                        mbus_clk;
    logic [short_addr_width-1:0] short_addr_override;
    logic [short_addr_width-1:0] assigned_addr_out;
    logic                        assigned_addr_write;
    logic                        assigned_addr_invalid_n;
    logic [short_addr_width-1:0] assigned_addr;
    logic                        assigned_addr_valid;
    logic [mbus_word_width-1:0]  rx_addr;
    logic [mbus_word_width-1:0]  rx_data;
    logic                        rx_req;
    logic                        rx_pend;
    logic                        rx_fail;
    logic                        rx_broadcast;
    logic [1:0]                  rx_control_bits;
    logic                        rx_ack;
    logic [byte_width-1:0]       global_counter;
    logic                        global_counter_inc;
    logic                        frame_valid;
    logic                        frame_data_valid;
    logic [byte_width-1:0]       frame_data;

    integer     seed;
    int         timeouts;
    int         frames_expected;
    bit         aborted;
    bit         in_message;
    logic [3:0] status_acc;

    mbus_rx_bridge #(
        .clk_div_width(clk_div_width)
    ) uut (
        .clk(clk), .reset(reset), .clk_div(clk_div), .mbus_clk(mbus_clk),
        .short_addr_override(short_addr_override), .assigned_addr_out(assigned_addr_out),
        .assigned_addr_write(assigned_addr_write),
        .assigned_addr_invalid_n(assigned_addr_invalid_n),
        .assigned_addr(assigned_addr), .assigned_addr_valid(assigned_addr_valid),
        .rx_addr(rx_addr), .rx_data(rx_data), .rx_req(rx_req), .rx_pend(rx_pend),
        .rx_fail(rx_fail), .rx_broadcast(rx_broadcast), .rx_control_bits(rx_control_bits),
        .rx_ack(rx_ack), .global_counter(global_counter),
        .global_counter_inc(global_counter_inc), .frame_valid(frame_valid),
        .frame_data_valid(frame_data_valid), .frame_data(frame_data)
    );

    rx_bridge_checker #(
        .clk_div_width(clk_div_width)
    ) chk (
        .clk(clk), .reset(reset), .frame_valid(frame_valid),
        .frame_data_valid(frame_data_valid), .frame_data(frame_data),
        .global_counter_inc(global_counter_inc), .global_counter(global_counter),
        .rx_ack(rx_ack), .mbus_clk(mbus_clk), .clk_div(clk_div),
        .assigned_addr(assigned_addr), .assigned_addr_valid(assigned_addr_valid)
    );

    // 40 ns clock
    always #20 clk = ~clk;

    // free running time tag source
    always @(posedge clk) begin
        global_counter <= global_counter + 1'b1;
    end

    // wait for rx_ack or frame_valid to reach a level on a falling edge
    task automatic wait_until(input bit on_ack, input logic level, input string what);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (((on_ack ? rx_ack : frame_valid) != level) && !aborted) begin
            cycles++;
            if (cycles > wait_limit) begin
                $display("timeout at %0t waiting for %s", $time, what);
                timeouts++;
                aborted = 1'b1;
            end else begin
                @(negedge clk);
            end
        end
    endtask

    // count mbus_clk edges of either polarity or rising only
    task automatic wait_mbus_edges(input bit rising_only, input int count);
        int seen;
        int cycles;
        logic last;
        seen = 0;
        cycles = 0;
        last = mbus_clk;
        while (seen < count && !aborted) begin
            @(negedge clk);
            cycles++;
            if (mbus_clk != last && (mbus_clk || !rising_only)) begin
                seen++;
            end
            last = mbus_clk;
            if (cycles > wait_limit) begin
                $display("timeout at %0t waiting for mbus_clk edges", $time);
                timeouts++;
                aborted = 1'b1;
            end
        end
    endtask

    task automatic set_divider(input logic [clk_div_width-1:0] new_div);
        // just after a toggle the divider count is still below any new value
        wait_mbus_edges(1'b0, 1);
        @(posedge clk);
        clk_div <= new_div;
        // a few full half periods for the checker
        wait_mbus_edges(1'b0, 5);
    endtask

    task automatic address_op(input logic [3:0] ovr, input logic wr, input logic inv_n,
                              input logic [3:0] aout, input logic [3:0] exp_addr,
                              input logic exp_valid);
        @(posedge clk);
        short_addr_override <= ovr;
        assigned_addr_write <= wr;
        assigned_addr_invalid_n <= inv_n;
        assigned_addr_out <= aout;
        // override shows up without waiting for the divided clock
        if (ovr != short_addr_none) begin
            @(negedge clk);
            chk.check_addr(exp_addr, exp_valid);
        end
        // levels held across two divided clock rising edges
        wait_mbus_edges(1'b1, 2);
        chk.check_addr(exp_addr, exp_valid);
        @(posedge clk);
        assigned_addr_write <= 1'b0;
        assigned_addr_invalid_n <= 1'b1;
    endtask

    // controller model for one received word
    task automatic send_word(input logic [31:0] addr, input logic [31:0] data,
                             input logic pend, input logic fail, input logic bcast,
                             input logic [1:0] ctrl);
        int i;
        @(posedge clk);
        if (!in_message) begin
            chk.expect_byte(frame_flag_byte);
            for (i = 3; i >= 0; i--) begin
                chk.expect_byte(addr[byte_width*i +: byte_width]);
            end
            status_acc = '0;
            in_message = 1'b1;
        end
        for (i = 3; i >= 0; i--) begin
            chk.expect_byte(data[byte_width*i +: byte_width]);
        end
        // status byte gathers flags of every word in the message
        status_acc = status_acc | {fail, bcast, ctrl};
        if (!pend) begin
            chk.expect_byte({4'b0000, status_acc});
            in_message = 1'b0;
            frames_expected++;
        end
        chk.expect_ack(1);
        rx_addr <= addr;
        rx_data <= data;
        rx_pend <= pend;
        rx_fail <= fail;
        rx_broadcast <= bcast;
        rx_control_bits <= ctrl;
        rx_req <= 1'b1;
        wait_until(1'b1, 1'b1, "rx_ack of a word");
        @(posedge clk);
        rx_req <= 1'b0;
        rx_fail <= 1'b0;
        if (!pend) begin
            wait_until(1'b0, 1'b0, "end of frame");
        end
    endtask

    task automatic failed_reception();
        @(posedge clk);
        chk.expect_ack(fail_ack_cycles);
        rx_fail <= 1'b1;
        wait_until(1'b1, 1'b1, "rx_ack after a failure");
        @(posedge clk);
        rx_fail <= 1'b0;
        wait_until(1'b1, 1'b0, "rx_ack to drop after a failure");
    endtask

    initial begin
        string line;
        string kind;
        string data_tok;
        int fd;
        int n;
        logic [31:0] a_val;
        logic [31:0] d_val;
        logic [3:0] ovr;
        logic [3:0] aout;
        logic [3:0] exp_addr;
        int f0;
        int f1;
        int f2;
        int f3;
        clk = 1'b0;
        reset = 1'b1;
        clk_div = 2;
        short_addr_override = short_addr_none;
        assigned_addr_out = '0;
        assigned_addr_write = 1'b0;
        assigned_addr_invalid_n = 1'b1;
        rx_addr = '0;
        rx_data = '0;
        rx_req = 1'b0;
        rx_pend = 1'b0;
        rx_fail = 1'b0;
        rx_broadcast = 1'b0;
        rx_control_bits = '0;
        global_counter = '0;
        seed = 32'h4140;
        timeouts = 0;
        frames_expected = 0;
        aborted = 1'b0;
        in_message = 1'b0;
        status_acc = '0;
        repeat (8) @(posedge clk);
        reset <= 1'b0;

        fd = $fopen("verification/rx_trace.txt", "r");
        if (fd == 0) begin
            $display("could not open the trace file");
            aborted = 1'b1;
        end
        while (!aborted && fd != 0 && !$feof(fd)) begin
            n = $fgets(line, fd);
            if (n > 0 && $sscanf(line, "%s", kind) == 1) begin
                case (kind)
                    "D": begin
                        n = $sscanf(line, "%s %h", kind, d_val);
                        set_divider(d_val[clk_div_width-1:0]);
                    end
                    "A": begin
                        n = $sscanf(line, "%s %h %d %d %h %h %d", kind, ovr, f0, f1, aout,
                                    exp_addr, f2);
                        address_op(ovr, f0[0], f1[0], aout, exp_addr, f2[0]);
                    end
                    "W": begin
                        n = $sscanf(line, "%s %h %s %d %d %d %d", kind, a_val, data_tok,
                                    f0, f1, f2, f3);
                        if (data_tok == "R") begin
                            d_val = $random(seed);
                        end else begin
                            n = $sscanf(data_tok, "%h", d_val);
                        end
                        send_word(a_val, d_val, f0[0], f1[0], f2[0], f3[1:0]);
                    end
                    "F": failed_reception();
                    // comment lines
                    default: begin
                    end
                endcase
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end

        // checker has handled the last falling edge by the next rising edge
        @(posedge clk);
        if (!aborted) begin
            chk.finish_checks(frames_expected);
        end
        $display("checks %0d errors %0d timeouts %0d", chk.check_count, chk.error_count,
                 timeouts);
        if (aborted || chk.error_count != 0) begin
            $display("Result: FAILED");
        end else begin
            $display("Result: PASSED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- mbus_rx_bridge.f
hdl/mbus_rx_pkg.sv
hdl/mbus_clock_divider.sv
hdl/short_addr_register.sv
hdl/rx_word_shifter.sv
hdl/rx_frame_controller.sv
hdl/mbus_rx_bridge.sv
verification/rx_bridge_checker.sv
verification/tb_mbus_rx_bridge.sv

//--- verification/rx_trace.txt
# D div | A override write invalid_n addr_out exp_addr exp_valid (hex fields)
# W addr data(hex, or R for random) pend fail broadcast control_bits | F failed reception
D 2
A f 1 1 5 5 1
A f 0 0 0 f 0
A 9 1 1 3 9 1
A f 0 1 0 3 1
A a 0 0 0 a 1
A f 0 1 0 f 0
A f 1 0 6 6 1
W 12345678 cafef00d 0 0 0 0
D 1
W 8badf00d R 0 0 1 2
W a0a1a2a3 R 1 0 0 1
W 00000000 R 1 0 1 0
W 00000000 11223344 0 1 0 0
F
D 5
W 0000000f deadbeef 0 0 1 3
D 3
A 7 0 1 0 7 1
A f 0 0 0 f 0
